// ==== build.f ====
+incdir+hdl
hdl/ifu_pkg.sv
hdl/imem_fetch_ctrl.sv
hdl/rdata_classify.sv
hdl/instr_queue.sv
hdl/ifu_top.sv
tb/ifu_props.sv
tb/ifu_tb.sv

// ==== hdl/ifu_cfg.svh ====
//------------------------------
// Fetch unit configuration macros
// Address, data and counter widths, queue size
//------------------------------

`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// Core and memory widths
`define IFU_XLEN            32
`define IFU_IMEM_AWIDTH     32
`define IFU_IMEM_DWIDTH     32

// Instruction queue depth, counted in halfwords
`define IFU_Q_SIZE_HALF     4

// Pending and discard counters, up to 7 transactions in flight
`define IFU_TXN_CNT_W       3

`endif

// ==== hdl/ifu_pkg.sv ====
//------------------------------
// Fetch unit shared types
// Memory response kind, fetched word union,
// queue write and decode-side output structs
//------------------------------

`include "ifu_cfg.svh"

package ifu_pkg;

    // Memory response kind
    typedef enum logic [1:0] {
        IMEM_RESP_IDLE   = 2'b00,
        IMEM_RESP_RDY_OK = 2'b01,
        IMEM_RESP_RDY_ER = 2'b10
    } imem_resp_e;

    // Queue write kind
    typedef enum logic [1:0] {
        Q_WE_NONE = 2'b00,                          // Nothing written
        Q_WE_HI   = 2'b01,                          // Upper halfword only
        Q_WE_FULL = 2'b10                           // Both halfwords
    } q_we_e;

    typedef struct packed {
        logic [`IFU_IMEM_DWIDTH/2-1:0] hi;
        logic [`IFU_IMEM_DWIDTH/2-1:0] lo;
    } half_pair_t;

    // One fetched word, seen whole or as two halfword slots
    typedef union packed {
        logic [`IFU_IMEM_DWIDTH-1:0] rvi;
        half_pair_t                  half;
    } rdata_word_u;

    typedef struct packed {
        q_we_e       kind;
        rdata_word_u word;
        logic        err;                           // Word came back with a fault
    } q_write_t;

    typedef struct packed {
        logic [`IFU_IMEM_DWIDTH-1:0] instr;
        logic                        imem_err;      // Access fault on this instruction
        logic                        err_rvi_hi;    // Fault only in upper half of RVI
    } idu_out_t;

endpackage

// ==== hdl/ifu_top.sv ====
//------------------------------
// Instruction fetch unit top level
//------------------------------

`include "ifu_cfg.svh"

module ifu_top
    import ifu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        imem_req_ack,
    input  logic [`IFU_IMEM_DWIDTH-1:0] imem_rdata,
    input  imem_resp_e                  imem_resp,
    input  logic                        new_pc_req,
    input  logic [`IFU_XLEN-1:0]        new_pc,
    input  logic                        stop_fetch,
    input  logic                        idu_rdy,
    output logic                        imem_req,
    output logic [`IFU_IMEM_AWIDTH-1:0] imem_addr,
    output logic                        idu_vd,
    output idu_out_t                    idu_out,
    output logic                        ifu_busy
);

logic       resp_vd;                                // Response not being dropped
logic [1:0] q_free_words;
logic       q_flush;
q_write_t   q_wr;

assign q_flush = new_pc_req | stop_fetch;

// Input side
imem_fetch_ctrl fetch_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .new_pc_req   (new_pc_req),
    .new_pc       (new_pc),
    .stop_fetch   (stop_fetch),
    .imem_req_ack (imem_req_ack),
    .imem_resp    (imem_resp),
    .q_free_words (q_free_words),
    .imem_req     (imem_req),
    .imem_addr    (imem_addr),
    .resp_vd      (resp_vd),
    .ifu_busy     (ifu_busy)
);

// Processing
rdata_classify classify_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .new_pc_req (new_pc_req),
    .new_pc_odd (new_pc[1]),
    .resp_vd    (resp_vd),
    .imem_resp  (imem_resp),
    .imem_rdata (imem_rdata),
    .q_wr       (q_wr)
);

// Output side
instr_queue queue_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (q_flush),
    .q_wr         (q_wr),
    .idu_rdy      (idu_rdy),
    .q_free_words (q_free_words),
    .idu_vd       (idu_vd),
    .idu_out      (idu_out)
);

endmodule

// ==== hdl/imem_fetch_ctrl.sv ====
//------------------------------
// Fetch control FSM
// Request address, pending and discard counters
//------------------------------

`include "ifu_cfg.svh"

module imem_fetch_ctrl
    import ifu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        new_pc_req,
    input  logic [`IFU_XLEN-1:0]        new_pc,
    input  logic                        stop_fetch,
    input  logic                        imem_req_ack,
    input  imem_resp_e                  imem_resp,
    input  logic [1:0]                  q_free_words,
    output logic                        imem_req,
    output logic [`IFU_IMEM_AWIDTH-1:0] imem_addr,
    output logic                        resp_vd,
    output logic                        ifu_busy
);

localparam int TXN_W = `IFU_TXN_CNT_W;

typedef enum logic {
    FSM_IDLE,
    FSM_FETCH
} fetch_fsm_e;

fetch_fsm_e             fsm;
logic [`IFU_XLEN-1:2]   addr_r;                     // Next word to request
logic [`IFU_XLEN-1:2]   fetch_word;
logic [TXN_W-1:0]       pend_cnt;                   // Accepted, not yet answered
logic [TXN_W-1:0]       disc_cnt;                   // Responses still to drop
logic [TXN_W-1:0]       disc_cnt_new;
logic [TXN_W-1:0]       vd_pend;
logic                   pend_full;
logic                   resp_ok;
logic                   resp_er;
logic                   resp_any;
logic                   discard;
logic                   req_acc;
logic                   fetch_go;

//------------------------------
// Response decode
//------------------------------
assign resp_ok  = (imem_resp == IMEM_RESP_RDY_OK);
assign resp_er  = (imem_resp == IMEM_RESP_RDY_ER);
assign resp_any = resp_ok | resp_er;
assign discard  = |disc_cnt;
assign resp_vd  = resp_any & ~discard;

//------------------------------
// Request side
//------------------------------
assign pend_full = &pend_cnt;
assign vd_pend   = pend_cnt - disc_cnt;             // Responses that will land in the queue
assign req_acc   = imem_req & imem_req_ack;

// Room for one more word once the valid in-flight words have landed
assign fetch_go  = (fsm == FSM_FETCH) & (TXN_W'(q_free_words) > vd_pend);
assign imem_req  = ~pend_full & ~stop_fetch & (new_pc_req | fetch_go);

assign fetch_word = new_pc_req ? new_pc[`IFU_XLEN-1:2] : addr_r;
assign imem_addr  = `IFU_IMEM_AWIDTH'({fetch_word, 2'b00});

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        addr_r <= '0;
    end else if (req_acc) begin
        addr_r <= fetch_word + 1'b1;                // Step past the accepted word
    end else if (new_pc_req) begin
        addr_r <= fetch_word;
    end
end

//------------------------------
// Transaction counters
//------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        pend_cnt <= '0;
    end else begin
        case ({req_acc, resp_any})
            2'b10:   pend_cnt <= pend_cnt + 1'b1;
            2'b01:   pend_cnt <= pend_cnt - 1'b1;
            default: pend_cnt <= pend_cnt;          // None, or one in and one out
        endcase
    end
end

always_comb begin
    logic [TXN_W-1:0] base;
    logic             dec;

    base = disc_cnt;
    dec  = 1'b0;
    if (new_pc_req) begin
        base = pend_cnt;                            // Everything in flight is stale
        dec  = resp_any;
    end else if (resp_er & ~discard) begin
        base = pend_cnt;                            // Drop all after the fault
        dec  = ~req_acc;
    end else if (resp_any & discard) begin
        dec  = 1'b1;
    end
    disc_cnt_new = base - dec;
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        disc_cnt <= '0;
    end else begin
        disc_cnt <= disc_cnt_new;
    end
end

//------------------------------
// Fetch FSM
//------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        fsm <= FSM_IDLE;
    end else begin
        case (fsm)
            FSM_IDLE: begin
                if (new_pc_req & ~stop_fetch) begin
                    fsm <= FSM_FETCH;
                end
            end
            FSM_FETCH: begin
                // A fault ends fetching unless a redirect arrives with it
                if (stop_fetch | (resp_er & ~discard & ~new_pc_req)) begin
                    fsm <= FSM_IDLE;
                end
            end
            default: fsm <= FSM_IDLE;
        endcase
    end
end

assign ifu_busy = (fsm == FSM_FETCH);

endmodule

// ==== hdl/instr_queue.sv ====
//------------------------------
// Halfword instruction queue
// Pointers, free words, decode-side output
//------------------------------

`include "ifu_cfg.svh"

module instr_queue
    import ifu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  q_write_t   q_wr,
    input  logic       idu_rdy,
    output logic [1:0] q_free_words,
    output logic       idu_vd,
    output idu_out_t   idu_out
);

localparam int Q_ADR_W = $clog2(`IFU_Q_SIZE_HALF);
localparam int Q_PTR_W = Q_ADR_W + 1;               // Extra bit tells full from empty
localparam int HALF_W  = `IFU_IMEM_DWIDTH / 2;

typedef enum logic [1:0] {
    RD_NONE,
    RD_HALF,
    RD_WORD
} q_rd_e;

logic [HALF_W-1:0]  q_data [`IFU_Q_SIZE_HALF];
logic               q_err  [`IFU_Q_SIZE_HALF];
logic [Q_PTR_W-1:0] rptr;
logic [Q_PTR_W-1:0] wptr;
logic [Q_PTR_W-1:0] rptr_next;
logic [Q_PTR_W-1:0] wptr_next;
logic [Q_PTR_W-1:0] q_ocpd;                         // Occupied halfwords
logic [Q_PTR_W-1:0] q_free_h;
logic [HALF_W-1:0]  head_data;
logic [HALF_W-1:0]  next_data;
logic               head_err;
logic               next_err;
logic               head_rvi;
logic               head_full_rvi;
logic               q_empty;
logic               out_vd;
logic               fault_sent;                     // Hold output until flush
q_rd_e              q_rd;
rdata_word_u        out_word;

assign q_empty   = (rptr == wptr);
assign q_ocpd    = wptr - rptr;
assign head_data = q_data[Q_ADR_W'(rptr)];
assign next_data = q_data[Q_ADR_W'(rptr + 1'b1)];
assign head_err  = q_err[Q_ADR_W'(rptr)];
assign next_err  = q_err[Q_ADR_W'(rptr + 1'b1)];
assign head_rvi  = &head_data[1:0];
assign head_full_rvi = head_rvi & ~head_err;

//------------------------------
// Pointers and storage
//------------------------------
always_comb begin
    q_rd = RD_NONE;
    if (idu_vd & idu_rdy) begin
        q_rd = head_full_rvi ? RD_WORD : RD_HALF;
    end
end

assign wptr_next = wptr + ((q_wr.kind == Q_WE_FULL) ? Q_PTR_W'(2) :
                           (q_wr.kind == Q_WE_HI)   ? Q_PTR_W'(1) : Q_PTR_W'(0));
assign rptr_next = rptr + ((q_rd == RD_WORD) ? Q_PTR_W'(2) :
                           (q_rd == RD_HALF) ? Q_PTR_W'(1) : Q_PTR_W'(0));

assign q_free_h     = Q_PTR_W'(`IFU_Q_SIZE_HALF) - (wptr_next - rptr_next);
assign q_free_words = 2'(q_free_h >> 1);

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        rptr       <= '0;
        wptr       <= '0;
        fault_sent <= 1'b0;
    end else if (flush) begin
        rptr       <= '0;
        wptr       <= '0;
        fault_sent <= 1'b0;
    end else begin
        rptr <= rptr_next;
        wptr <= wptr_next;
        if (idu_vd & idu_rdy & idu_out.imem_err) begin
            fault_sent <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (~flush) begin
        case (q_wr.kind)
            Q_WE_HI: begin
                q_data[Q_ADR_W'(wptr)] <= q_wr.word.half.hi;
                q_err[Q_ADR_W'(wptr)]  <= q_wr.err;
            end
            Q_WE_FULL: begin
                q_data[Q_ADR_W'(wptr)]        <= q_wr.word.half.lo;
                q_err[Q_ADR_W'(wptr)]         <= q_wr.err;
                q_data[Q_ADR_W'(wptr + 1'b1)] <= q_wr.word.half.hi;
                q_err[Q_ADR_W'(wptr + 1'b1)]  <= q_wr.err;
            end
            default: begin
            end
        endcase
    end
end

//------------------------------
// Decode-side output
//------------------------------
always_comb begin
    out_vd             = 1'b0;
    idu_out.imem_err   = 1'b0;
    idu_out.err_rvi_hi = 1'b0;
    out_word.half.lo   = head_data;
    out_word.half.hi   = head_full_rvi ? next_data : '0;  // RVC and faulted heads zero-extend
    idu_out.instr      = out_word.rvi;
    if (~q_empty) begin
        if (q_ocpd == Q_PTR_W'(1)) begin
            out_vd           = ~head_rvi | head_err;      // Lone RVI half must wait
            idu_out.imem_err = head_err;
        end else begin
            out_vd             = 1'b1;
            idu_out.imem_err   = head_err | (head_rvi & next_err);
            idu_out.err_rvi_hi = ~head_err & head_rvi & next_err;
        end
    end
end

assign idu_vd = out_vd & ~fault_sent;

endmodule

// ==== hdl/rdata_classify.sv ====
//------------------------------
// Response word classifier
// Picks the queue write kind for each word
//------------------------------

module rdata_classify
    import ifu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        new_pc_req,
    input  logic        new_pc_odd,
    input  logic        resp_vd,
    input  imem_resp_e  imem_resp,
    input  rdata_word_u imem_rdata,
    output q_write_t    q_wr
);

logic resp_er;
logic odd_start;                                    // First word after odd redirect

assign resp_er = (imem_resp == IMEM_RESP_RDY_ER);

//------------------------------
// Odd-start tracking
//------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        odd_start <= 1'b0;
    end else if (new_pc_req) begin
        odd_start <= new_pc_odd;
    end else if (resp_vd) begin
        odd_start <= 1'b0;
    end
end

//------------------------------
// Queue write
//------------------------------
always_comb begin
    q_wr.kind = Q_WE_NONE;
    q_wr.word = imem_rdata;
    q_wr.err  = resp_er;
    if (resp_vd) begin
        if (odd_start & ~resp_er) begin
            q_wr.kind = Q_WE_HI;                    // Low half lies before the target
        end else begin
            q_wr.kind = Q_WE_FULL;
        end
    end
end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module ifu_tb \
    -o ifu_sim

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/ifu_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== tb/ifu_golden.txt ====
// Fetch unit golden data, 36-bit hex values, $readmemh format
// @00 memory image: {error flag, data word}, word address 0 upward
// @20 per test: start pc, {redirect flag, mid pc}, transfers before mid redirect,
//     {back-pressure flag, first expected index, expected count}
// @40 expected transfers: {fault, upper-half fault, instruction}

@00
000100093 000200113 000300193 000400213   // Words 0-3, pure RVI
045854501 086330505 0808200a5 000000013   // Words 4-7, RVC pairs, add straddles 5/6
046851117 000d50733 080820705 007934705   // Words 8-11, odd target at 0x22
100130010 000500293 043854305 000628333   // Words 12-15, word 12 faults

@20
000000000 000000000 000000000 000000004   // 1, aligned RVI
000000010 000000000 000000000 000000406   // 2, mixed RVC and RVI
000000022 000000000 000000000 000000a04   // 3, odd halfword start
00000002c 000000000 000000000 000000e02   // 4, fault in RVI upper half
000000000 100000034 000000002 000001006   // 5, redirect after two
000000000 000000000 000000000 10000160a   // 6, back-pressure over tests 1 and 2

@40
// Test 1
000100093 000200113 000300193 000400213
// Test 2
000004501 000004585 000000505 000a58633
000008082 000000013
// Test 3
000004685 000d50733 000000705 000008082
// Test 4
000004705 300100793
// Test 5
000100093 000200113 000500293 000004305
000004385 000628333
// Test 6
000100093 000200113 000300193 000400213
000004501 000004585 000000505 000a58633
000008082 000000013

// ==== tb/ifu_props.sv ====
//------------------------------
// Fetch unit port properties
// Bound to the top level
//------------------------------

`include "ifu_cfg.svh"

module ifu_props
    import ifu_pkg::*;
(
    input logic                        clk,
    input logic                        rst_n,
    input logic                        new_pc_req,
    input logic                        stop_fetch,
    input logic                        imem_req,
    input logic [`IFU_IMEM_AWIDTH-1:0] imem_addr,
    input logic                        idu_vd,
    input logic                        idu_rdy,
    input idu_out_t                    idu_out
);

int unsigned prop_fails = 0;                        // Failed property count

addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req |-> (imem_addr[1:0] == 2'b00))
    else begin
        $error("imem_addr not word aligned during a request");
        prop_fails = prop_fails + 1;
    end

// Held output must not move until it is taken
out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (idu_vd && !idu_rdy && !new_pc_req && !stop_fetch) |=> $stable(idu_out))
    else begin
        $error("idu_out changed while stalled by decode");
        prop_fails = prop_fails + 1;
    end

hi_fault_flag: assert property (@(posedge clk) disable iff (!rst_n)
    idu_out.err_rvi_hi |-> idu_out.imem_err)
    else begin
        $error("upper-half fault flag set without the fault flag");
        prop_fails = prop_fails + 1;
    end

flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (new_pc_req || stop_fetch) |=> !idu_vd)
    else begin
        $error("idu_vd high in the cycle after a flush");
        prop_fails = prop_fails + 1;
    end

endmodule

bind ifu_top ifu_props ifu_props_i (.*);

// ==== tb/ifu_tb.sv ====
//------------------------------
// Fetch unit testbench
// Clock, reset, memory model, decode-stage consumer
// and golden-file checks
//------------------------------

`include "ifu_cfg.svh"

module ifu_tb
    import ifu_pkg::*;
();

localparam int GOLD_DEPTH   = 128;
localparam int MEM_BASE     = 'h00;                 // Memory image, 16 words
localparam int TEST_BASE    = 'h20;                 // Four fields per test
localparam int EXP_BASE     = 'h40;                 // Expected transfers
localparam int NUM_TESTS    = 6;
localparam int QUIET_CYCLES = 20;

logic                        clk;
logic                        rst_n;
logic                        imem_req_ack;
logic [`IFU_IMEM_DWIDTH-1:0] imem_rdata;
imem_resp_e                  imem_resp;
logic                        new_pc_req;
logic [`IFU_XLEN-1:0]        new_pc;
logic                        stop_fetch;
logic                        idu_rdy;
logic                        imem_req;
logic [`IFU_IMEM_AWIDTH-1:0] imem_addr;
logic                        idu_vd;
idu_out_t                    idu_out;
logic                        ifu_busy;

logic [35:0]                 gold [GOLD_DEPTH];
logic [`IFU_IMEM_AWIDTH-1:0] addr_q [$];           // Accepted, not yet answered
int                          resp_wait   = 0;
int                          cycle_cnt   = 0;
int                          cycle_limit = 0;
int                          err_cnt     = 0;
int                          test_fails  = 0;

ifu_top ifu_top_i (.*);

initial begin
    clk = 1'b0;
    forever begin
        #2 clk = ~clk;
    end
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
        $display("Timeout: run still going after %0d cycles", cycle_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end
end

//------------------------------
// Memory model, in-order responses
//------------------------------
always @(posedge clk) begin
    logic [`IFU_IMEM_AWIDTH-1:0] word_adr;
    logic [35:0]                 entry;

    if (imem_req && imem_req_ack) begin
        addr_q.push_back(imem_addr);
    end
    imem_req_ack <= ($urandom_range(3, 0) != 0);    // Stall about one cycle in four
    if (resp_wait > 0) begin
        resp_wait = resp_wait - 1;
        imem_resp <= IMEM_RESP_IDLE;
    end else if (addr_q.size() > 0) begin
        word_adr = addr_q.pop_front();
        entry    = gold[MEM_BASE + int'(word_adr[5:2])];  // Image repeats every 64 bytes
        imem_rdata <= entry[31:0];
        imem_resp  <= entry[32] ? IMEM_RESP_RDY_ER : IMEM_RESP_RDY_OK;
        resp_wait  = int'($urandom_range(3, 0));
    end else begin
        imem_resp <= IMEM_RESP_IDLE;
    end
end

function automatic logic pick_rdy(input logic bp);
    return bp ? ($urandom_range(2, 0) != 0) : 1'b1;
endfunction

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
        $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
        err_cnt++;
    end
endtask

task automatic check_transfer(input int idx);
    logic [35:0] exp_e;

    exp_e = gold[EXP_BASE + idx];
    compare_value("idu_out.instr", idu_out.instr, exp_e[31:0]);
    compare_value("idu_out.imem_err", 32'(idu_out.imem_err), 32'(exp_e[33]));
    compare_value("idu_out.err_rvi_hi", 32'(idu_out.err_rvi_hi), 32'(exp_e[32]));
endtask

task automatic run_test(input int t);
    logic [35:0] start_f;
    logic [35:0] mid_f;
    logic [35:0] exp_f;
    int          base;
    int          count;
    int          mid_at;
    int          got;
    int          err_start;
    logic        bp;
    logic        fire;
    logic        mid_done;
    logic        fault_end;
    logic        busy_seen;

    start_f   = gold[TEST_BASE + 4*t];
    mid_f     = gold[TEST_BASE + 4*t + 1];
    exp_f     = gold[TEST_BASE + 4*t + 3];
    base      = int'(exp_f[15:8]);
    count     = int'(exp_f[7:0]);
    bp        = exp_f[32];
    mid_at    = mid_f[32] ? int'(gold[TEST_BASE + 4*t + 2][7:0]) : -1;
    fault_end = gold[EXP_BASE + base + count - 1][33];
    got       = 0;
    mid_done  = 1'b0;
    busy_seen = 1'b0;
    err_start = err_cnt;

    @(posedge clk);
    new_pc_req <= 1'b1;                             // Start redirect
    new_pc     <= start_f[31:0];
    idu_rdy    <= 1'b0;
    while (got < count) begin
        @(posedge clk);
        busy_seen = busy_seen | ifu_busy;
        if (idu_vd && idu_rdy) begin
            check_transfer(base + got);
            got++;
        end
        fire = (got == mid_at) && !mid_done;
        new_pc_req <= fire;
        if (fire) begin
            mid_done = 1'b1;
            new_pc  <= mid_f[31:0];
            idu_rdy <= 1'b0;
        end else begin
            idu_rdy <= (got < count) ? pick_rdy(bp) : 1'b0;
        end
    end

    assert (busy_seen) else begin
        $display("Error: time %0t, ifu_busy stayed low while fetching", $time);
        err_cnt++;
    end

    // After a fault nothing more may reach decode
    if (fault_end) begin
        idu_rdy <= 1'b1;
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            assert (!(idu_vd && idu_rdy)) else begin
                $display("Error: time %0t, an instruction arrived after the fault", $time);
                err_cnt++;
            end
        end
        compare_value("ifu_busy", 32'(ifu_busy), 32'd0);
        idu_rdy <= 1'b0;
    end

    if (err_cnt == err_start) begin
        $display("Test %0d passed: %0d instructions from %h", t + 1, count, start_f[31:0]);
    end else begin
        $display("Test %0d failed: %0d errors", t + 1, err_cnt - err_start);
        test_fails++;
    end
endtask

//------------------------------
// Main sequence
//------------------------------
initial begin
    int total;

    void'($urandom(32'hbb5b));
    rst_n        = 1'b0;
    imem_req_ack = 1'b0;
    imem_rdata   = '0;
    imem_resp    = IMEM_RESP_IDLE;
    new_pc_req   = 1'b0;
    new_pc       = '0;
    stop_fetch   = 1'b0;
    idu_rdy      = 1'b0;
    $readmemh("tb/ifu_golden.txt", gold);
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
        total += int'(gold[TEST_BASE + 4*t + 3][7:0]);
    end
    cycle_limit = 40 * total + 100;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
        run_test(t);
    end

    // stop_fetch ends fetching
    @(posedge clk);
    stop_fetch <= 1'b1;
    @(posedge clk);
    stop_fetch <= 1'b0;
    @(posedge clk);
    compare_value("ifu_busy", 32'(ifu_busy), 32'd0);

    $display("Tests run: %0d, failed: %0d, check errors: %0d, property failures: %0d",
             NUM_TESTS, test_fails, err_cnt, ifu_top_i.ifu_props_i.prop_fails);
    if ((err_cnt == 0) && (test_fails == 0) && (ifu_top_i.ifu_props_i.prop_fails == 0)) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule
